// File: Makefile
SIM  := obj_dir/Vdetector_ctrl_tb
SRCS := $(shell cat detector_ctrl_top.f)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): detector_ctrl_top.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module detector_ctrl_tb \
		-f detector_ctrl_top.f

# Pass only if the testbench printed its pass line
run: $(SIM)
	@out="$$(./$(SIM) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TESTS PASSED'

clean:
	rm -rf obj_dir

// File: detector_ctrl_top.f
hdl/serial_cmd_pkg.sv
hdl/detector_ctrl_pkg.sv
hdl/reg_bus_if.sv
hdl/serial_frame_engine.sv
hdl/ctrl_reg_slice.sv
hdl/readback_mux.sv
hdl/detector_ctrl_top.sv
dv/detector_ctrl_properties.sv
dv/detector_ctrl_tb.sv

// File: dv/detector_ctrl_properties.sv
`timescale 1ns/1ps

module detector_ctrl_properties (
    input logic       clk,
    input logic       arst_n,
    input logic       rx_valid,
    input logic       rx_ready,
    input logic [7:0] tx_byte,
    input logic       tx_valid,
    input logic       tx_ready,
    input logic       wr_stb
);

    int unsigned fail_cnt = 0;

    // --------------------
    // Transmit handshake
    // --------------------
    property p_tx_hold;
        @(posedge clk) disable iff (!arst_n)
            (tx_valid && !tx_ready) |=> (tx_valid && $stable(tx_byte));
    endproperty

    property p_no_rx_during_tx;
        @(posedge clk) disable iff (!arst_n)
            tx_valid |-> !rx_ready;
    endproperty

    // --------------------
    // Write strobe
    // --------------------
    property p_wr_stb_single;
        @(posedge clk) disable iff (!arst_n)
            wr_stb |=> !wr_stb;
    endproperty

    property p_wr_stb_after_byte;
        @(posedge clk) disable iff (!arst_n)
            $rose(wr_stb) |-> $past(rx_valid && rx_ready);  // Right after the last data byte
    endproperty

    a_tx_hold: assert property (p_tx_hold)
    else
    begin
        fail_cnt++;
        $error("tx_byte or tx_valid changed while tx_ready was low");
    end

    a_no_rx_during_tx: assert property (p_no_rx_during_tx)
    else
    begin
        fail_cnt++;
        $error("rx_ready high while a read word is being sent");
    end

    a_wr_stb_single: assert property (p_wr_stb_single)
    else
    begin
        fail_cnt++;
        $error("wr_stb stayed high for more than one cycle");
    end

    a_wr_stb_after_byte: assert property (p_wr_stb_after_byte)
    else
    begin
        fail_cnt++;
        $error("wr_stb rose without a byte transfer on the edge before");
    end

endmodule

// File: dv/detector_ctrl_tb.sv
`timescale 1ns/1ps

module detector_ctrl_tb
    import serial_cmd_pkg::*;
    import detector_ctrl_pkg::*;
();

    localparam int RESET_CYCLES     = 3;
    localparam int NUM_FRAMES       = 80;   // Counted from the sequence below, rounded up
    localparam int FRAME_CYCLES_MAX = 64;   // Nine bytes plus random tx stalls
    localparam int TIMEOUT_CYCLES   = RESET_CYCLES + NUM_FRAMES * FRAME_CYCLES_MAX;

    logic        clk;
    logic        arst_n;
    logic [7:0]  rx_byte;
    logic        rx_valid;
    logic        rx_ready;
    logic [7:0]  tx_byte;
    logic        tx_valid;
    logic        tx_ready;
    logic [31:0] halfstrips;
    logic [31:0] halfstrips_errcnt;
    logic        compout_last, pulser_ready, adc_miso, ddd_miso;

    // DUT field outputs
    logic [2:0]  pktime;
    logic [1:0]  pkmode;
    logic        lctrst, cdac_en_n, cdac_din, cdac_sclk;
    logic        fire_pulse;
    logic [3:0]  pulse_width;
    logic [2:0]  bx_delay;
    logic        pdac_en_n, pdac_din, pdac_sclk;
    logic        halfstrips_errcnt_rst, compout_errcnt_rst, compin_inject, compout_expect;
    logic [3:0]  triad_persist;
    logic        triad_persist1;
    logic [15:0] mux_a0;
    logic [15:0] mux_a1;
    logic        mux_a0_prev, mux_a1_prev, mux_a0_next, mux_a1_next;
    logic [31:0] halfstrips_expect;
    logic [31:0] active_strip_mask;
    logic        adc_cs_n, adc_mosi, adc_sclk;
    logic        ddd_al_n, ddd_mosi, ddd_sclk;

    int unsigned errors = 0;
    int unsigned checks = 0;
    int unsigned cycles = 0;
    bit          stall_en;
    logic [31:0] shadow [NUM_CTRL_REGS];    // Expected stored word per writable register

    detector_ctrl_top u_detector_ctrl_top (.*);

    bind detector_ctrl_top detector_ctrl_properties u_props (
        .clk      (clk),
        .arst_n   (arst_n),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .tx_byte  (tx_byte),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .wr_stb   (u_reg_bus.wr_stb)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // --------------------
    // Host side helpers
    // --------------------
    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("MISMATCH time=%0t signal=%s got=%08h exp=%08h", $time, name, got, exp);
        end
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic send_byte(input logic [7:0] b);
        logic taken;
        taken    = 1'b0;
        rx_byte  = b;
        rx_valid = 1'b1;
        while (!taken)
        begin
            @(negedge clk);
            taken = rx_ready;   // Transfer happens at the coming edge
            @(posedge clk);
            #1;
        end
        rx_valid = 1'b0;
    endtask

    task automatic recv_byte(output logic [7:0] b);
        logic taken;
        taken = 1'b0;
        b     = 8'h00;
        while (!taken)
        begin
            tx_ready = stall_en ? (($urandom() % 3) != 0) : 1'b1;
            @(negedge clk);
            taken = tx_valid && tx_ready;
            b     = tx_byte;
            @(posedge clk);
            #1;
        end
        tx_ready = 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] adr, input logic [31:0] w);
        send_byte({adr, OP_WRITE});
        for (int k = 0; k < WORD_BYTES; k++)
            send_byte(w[8*k +: 8]);     // LSB first
    endtask

    task automatic read_reg(input logic [3:0] adr, output logic [31:0] w);
        logic [7:0] b;
        w = 32'h0;
        send_byte({adr, OP_READ});
        for (int k = 0; k < WORD_BYTES; k++)
        begin
            recv_byte(b);
            w[8*k +: 8] = b;
        end
    endtask

    // Readback model from the address map and status overlay rules
    function automatic logic [31:0] expected_rd(input logic [3:0] adr);
        logic [31:0] w;
        w = 32'hDEAD_BEEF;
        if (adr == ADR_HALFSTRIPS)
            w = halfstrips;
        else if (adr == ADR_HALFSTRIPS_ERRCNT)
            w = halfstrips_errcnt;
        for (int s = 0; s < NUM_CTRL_REGS; s++)
            if (adr == CTRL_ADDR[s])
                w = shadow[s];
        if (adr == CTRL_ADDR[REG_PULSE_CTRL])
        begin
            w[COMPOUT_LAST_BIT] = compout_last;
            w[PULSER_READY_BIT] = pulser_ready;
        end
        else if (adr == CTRL_ADDR[REG_ADC])
            w[MISO_BIT] = adc_miso;
        else if (adr == CTRL_ADDR[REG_DDD])
            w[MISO_BIT] = ddd_miso;
        return w;
    endfunction

    task automatic check_read(input logic [3:0] adr);
        logic [31:0] got;
        read_reg(adr, got);
        check_word($sformatf("rdata[adr=%h]", adr), got, expected_rd(adr));
    endtask

    // Field outputs packed back into their register word
    task automatic check_fields(input int slot);
        logic [31:0] obs;
        obs = 32'h0;
        case (slot)
            REG_COMP_CFG:
                obs = {23'h0, cdac_sclk, cdac_din, cdac_en_n, lctrst, pkmode, pktime};
            REG_PULSE_CTRL:
                obs = {12'h0, triad_persist1, triad_persist, compout_expect, bx_delay,
                       compin_inject, compout_errcnt_rst, halfstrips_errcnt_rst,
                       pdac_sclk, pdac_din, pdac_en_n, pulse_width, fire_pulse};
            REG_MUX1:
                obs = {28'h0, mux_a1_next, mux_a0_next, mux_a1_prev, mux_a0_prev};
            REG_MUX2:
            begin
                for (int i = 0; i < 16; i++)
                begin
                    obs[2*i]     = mux_a0[i];
                    obs[2*i + 1] = mux_a1[i];
                end
            end
            REG_HS_EXPECT:  obs = halfstrips_expect;
            REG_STRIP_MASK: obs = active_strip_mask;
            REG_ADC:        obs = {29'h0, adc_sclk, adc_mosi, adc_cs_n};
            default:        obs = {29'h0, ddd_sclk, ddd_mosi, ddd_al_n};
        endcase
        check_word($sformatf("fields[reg %0d]", slot), obs, shadow[slot]);
    endtask

    task automatic write_and_check(input int slot, input logic [31:0] w);
        write_reg(CTRL_ADDR[slot], w);
        shadow[slot] = w & CTRL_MASK[slot];
        @(posedge clk);     // Second edge after the last data byte
        #1;
        check_fields(slot);
        check_read(CTRL_ADDR[slot]);
    endtask

    // --------------------
    // Timeout
    // --------------------
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles > TIMEOUT_CYCLES)
        begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycles);
            $display("checks=%0d errors=%0d property_failures=%0d", checks, errors,
                     u_detector_ctrl_top.u_props.fail_cnt);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // --------------------
    // Sequence
    // --------------------
    initial
    begin
        int unsigned prop_fails;
        void'($urandom(32'h738b));
        arst_n            = 1'b0;
        rx_byte           = 8'h00;
        rx_valid          = 1'b0;
        tx_ready          = 1'b0;
        halfstrips        = $urandom();
        halfstrips_errcnt = $urandom();
        {compout_last, pulser_ready, adc_miso, ddd_miso} = 4'b0000;
        stall_en          = 1'b0;
        for (int s = 0; s < NUM_CTRL_REGS; s++)
            shadow[s] = CTRL_RESET[s];
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arst_n = 1'b1;

        for (int s = 0; s < NUM_CTRL_REGS; s++)
            check_read(CTRL_ADDR[s]);       // Reset words

        for (int s = 0; s < NUM_CTRL_REGS; s++)
            write_and_check(s, $urandom());

        send_byte(8'h20);                   // Unknown opcode, swallowed
        for (int a = 0; a < 16; a++)
            check_read(4'(a));              // Whole map incl. unmapped and read-only

        // Status overlays
        {compout_last, pulser_ready, adc_miso, ddd_miso} = 4'b1010;
        check_read(CTRL_ADDR[REG_PULSE_CTRL]);
        check_read(CTRL_ADDR[REG_ADC]);
        check_read(CTRL_ADDR[REG_DDD]);
        {compout_last, pulser_ready, adc_miso, ddd_miso} = 4'b0101;
        check_read(CTRL_ADDR[REG_PULSE_CTRL]);
        check_read(CTRL_ADDR[REG_ADC]);
        check_read(CTRL_ADDR[REG_DDD]);

        // Random tx back-pressure
        stall_en = 1'b1;
        for (int s = 0; s < NUM_CTRL_REGS; s++)
            write_and_check(s, $urandom());
        for (int a = 0; a < 16; a++)
        begin
            {compout_last, pulser_ready, adc_miso, ddd_miso} = 4'($urandom());
            check_read(4'(a));
        end

        repeat (2) @(posedge clk);
        prop_fails = u_detector_ctrl_top.u_props.fail_cnt;
        $display("checks=%0d errors=%0d property_failures=%0d", checks, errors, prop_fails);
        if ((errors == 0) && (prop_fails == 0))
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: hdl/ctrl_reg_slice.sv
`timescale 1ns/1ps

module ctrl_reg_slice
    import serial_cmd_pkg::*;
    import detector_ctrl_pkg::*;
#(
    parameter logic [3:0]  ADDR        = CTRL_ADDR[0],
    parameter logic [31:0] RESET_VALUE = CTRL_RESET[0],
    parameter logic [31:0] WRITE_MASK  = CTRL_MASK[0]
)
(
    input  logic        clk,
    input  logic        arst_n,
    reg_bus_if.slice    bus,
    output logic [31:0] word,
    output logic [31:0] rd_word
);

    logic adr_hit;

    assign adr_hit = (bus.adr == ADDR);

    // Bits outside the mask stay constant zero
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            word <= RESET_VALUE & WRITE_MASK;
        else if (bus.wr_stb && adr_hit)
            word <= bus.wdata & WRITE_MASK;
    end

    // Zero when not addressed so the readback can OR all slices
    assign rd_word = adr_hit ? word : 32'h0;

endmodule

// File: hdl/detector_ctrl_pkg.sv
package detector_ctrl_pkg;

    import serial_cmd_pkg::*;

    // --------------------
    // Field positions
    // --------------------

    // Comparator config
    localparam int PKTIME_LSB    = 0;   // 3 bits
    localparam int PKMODE_LSB    = 3;   // 2 bits
    localparam int LCTRST_BIT    = 5;
    localparam int CDAC_EN_N_BIT = 6;
    localparam int CDAC_DIN_BIT  = 7;
    localparam int CDAC_SCLK_BIT = 8;

    // Pulse control, must agree with pulse_ctrl_u below
    localparam int FIRE_PULSE_BIT         = 0;
    localparam int PULSE_WIDTH_LSB        = 1;  // 4 bits
    localparam int PDAC_EN_N_BIT          = 5;
    localparam int PDAC_DIN_BIT           = 6;
    localparam int PDAC_SCLK_BIT          = 7;
    localparam int HS_ERRCNT_RST_BIT      = 8;
    localparam int COMPOUT_ERRCNT_RST_BIT = 9;
    localparam int COMPIN_INJECT_BIT      = 10;
    localparam int BX_DELAY_LSB           = 11; // 3 bits
    localparam int COMPOUT_EXPECT_BIT     = 14;
    localparam int TRIAD_PERSIST_LSB      = 15; // 4 bits
    localparam int TRIAD_PERSIST1_BIT     = 19;
    localparam int COMPOUT_LAST_BIT       = 20; // Status, read only
    localparam int PULSER_READY_BIT       = 21; // Status, read only

    // Mux 1
    localparam int MUX_A0_PREV_BIT = 0;
    localparam int MUX_A1_PREV_BIT = 1;
    localparam int MUX_A0_NEXT_BIT = 2;
    localparam int MUX_A1_NEXT_BIT = 3;

    // ADC and DDD bit-bang ports share one layout
    localparam int ADC_CS_N_BIT  = 0;
    localparam int ADC_MOSI_BIT  = 1;
    localparam int ADC_SCLK_BIT  = 2;
    localparam int DDD_AL_N_BIT  = 0;
    localparam int DDD_MOSI_BIT  = 1;
    localparam int DDD_SCLK_BIT  = 2;
    localparam int MISO_BIT      = 3;

    // --------------------
    // Reset words and masks
    // --------------------

    // Active-low selects park high
    localparam logic [31:0] CTRL_RESET [NUM_CTRL_REGS] = '{
        32'h0,
        32'(1) << PDAC_EN_N_BIT,
        32'h0,
        32'h0,
        32'h0,
        32'h0,
        32'(1) << ADC_CS_N_BIT,
        32'(1) << DDD_AL_N_BIT
    };

    localparam logic [31:0] CTRL_MASK [NUM_CTRL_REGS] = '{
        32'h0000_01FF,  // Comparator config
        32'h000F_FFFF,  // Pulse control
        32'h0000_000F,  // Mux 1
        32'hFFFF_FFFF,
        32'hFFFF_FFFF,
        32'hFFFF_FFFF,
        32'h0000_0007,  // ADC
        32'h0000_0007   // DDD
    };

    // Pulse control word, written as fields, read back with status on top
    typedef union packed {
        struct packed {
            logic [11:0] rsvd;
            logic        triad_persist1;
            logic [3:0]  triad_persist;
            logic        compout_expect;
            logic [2:0]  bx_delay;
            logic        compin_inject;
            logic        compout_errcnt_rst;
            logic        halfstrips_errcnt_rst;
            logic        pdac_sclk;
            logic        pdac_din;
            logic        pdac_en_n;
            logic [3:0]  pulse_width;
            logic        fire_pulse;
        } ctrl;
        struct packed {
            logic [9:0]  rsvd;
            logic        pulser_ready;
            logic        compout_last;
            logic [19:0] ctrl_bits;
        } rb;
    } pulse_ctrl_u;

endpackage

// File: hdl/detector_ctrl_top.sv
`timescale 1ns/1ps

module detector_ctrl_top
    import serial_cmd_pkg::*;
    import detector_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,

    // Host byte stream
    input  logic [7:0]  rx_byte,
    input  logic        rx_valid,
    output logic        rx_ready,
    output logic [7:0]  tx_byte,
    output logic        tx_valid,
    input  logic        tx_ready,

    // Board status
    input  logic [31:0] halfstrips,
    input  logic [31:0] halfstrips_errcnt,
    input  logic        compout_last,
    input  logic        pulser_ready,
    input  logic        adc_miso,
    input  logic        ddd_miso,

    // Comparator config
    output logic [2:0]  pktime,
    output logic [1:0]  pkmode,
    output logic        lctrst,
    output logic        cdac_en_n,
    output logic        cdac_din,
    output logic        cdac_sclk,

    // Pulse control
    output logic        fire_pulse,
    output logic [3:0]  pulse_width,
    output logic [2:0]  bx_delay,
    output logic        pdac_en_n,
    output logic        pdac_din,
    output logic        pdac_sclk,
    output logic        halfstrips_errcnt_rst,
    output logic        compout_errcnt_rst,
    output logic        compin_inject,
    output logic        compout_expect,
    output logic [3:0]  triad_persist,
    output logic        triad_persist1,

    // Mux select
    output logic [15:0] mux_a0,
    output logic [15:0] mux_a1,
    output logic        mux_a0_prev,
    output logic        mux_a1_prev,
    output logic        mux_a0_next,
    output logic        mux_a1_next,

    output logic [31:0] halfstrips_expect,
    output logic [31:0] active_strip_mask,

    // Bit-bang ports
    output logic        adc_cs_n,
    output logic        adc_mosi,
    output logic        adc_sclk,
    output logic        ddd_al_n,
    output logic        ddd_mosi,
    output logic        ddd_sclk
);

    logic [NUM_CTRL_REGS-1:0][31:0] slice_word;
    logic [NUM_CTRL_REGS-1:0][31:0] slice_rd;
    logic [31:0]                    comp_w;
    logic [31:0]                    mux1_w;
    logic [31:0]                    mux2_w;
    logic [31:0]                    adc_w;
    logic [31:0]                    ddd_w;
    pulse_ctrl_u                    pulse_w;

    reg_bus_if u_reg_bus ();

    serial_frame_engine u_engine (
        .clk      (clk),
        .arst_n   (arst_n),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid),
        .rx_ready (rx_ready),
        .tx_byte  (tx_byte),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .bus      (u_reg_bus)
    );

    // --------------------
    // Register slices
    // --------------------
    for (genvar i = 0; i < NUM_CTRL_REGS; i++)
    begin : g_slice
        ctrl_reg_slice #(
            .ADDR        (CTRL_ADDR[i]),
            .RESET_VALUE (CTRL_RESET[i]),
            .WRITE_MASK  (CTRL_MASK[i])
        ) u_slice (
            .clk     (clk),
            .arst_n  (arst_n),
            .bus     (u_reg_bus),
            .word    (slice_word[i]),
            .rd_word (slice_rd[i])
        );
    end

    readback_mux u_readback (
        .bus               (u_reg_bus),
        .slice_rd          (slice_rd),
        .halfstrips        (halfstrips),
        .halfstrips_errcnt (halfstrips_errcnt),
        .compout_last      (compout_last),
        .pulser_ready      (pulser_ready),
        .adc_miso          (adc_miso),
        .ddd_miso          (ddd_miso)
    );

    // --------------------
    // Field outputs
    // --------------------
    assign comp_w  = slice_word[REG_COMP_CFG];
    assign pulse_w = slice_word[REG_PULSE_CTRL];
    assign mux1_w  = slice_word[REG_MUX1];
    assign mux2_w  = slice_word[REG_MUX2];
    assign adc_w   = slice_word[REG_ADC];
    assign ddd_w   = slice_word[REG_DDD];

    assign pktime    = comp_w[PKTIME_LSB +: 3];
    assign pkmode    = comp_w[PKMODE_LSB +: 2];
    assign lctrst    = comp_w[LCTRST_BIT];
    assign cdac_en_n = comp_w[CDAC_EN_N_BIT];
    assign cdac_din  = comp_w[CDAC_DIN_BIT];
    assign cdac_sclk = comp_w[CDAC_SCLK_BIT];

    assign fire_pulse            = pulse_w.ctrl.fire_pulse;
    assign pulse_width           = pulse_w.ctrl.pulse_width;
    assign pdac_en_n             = pulse_w.ctrl.pdac_en_n;
    assign pdac_din              = pulse_w.ctrl.pdac_din;
    assign pdac_sclk             = pulse_w.ctrl.pdac_sclk;
    assign halfstrips_errcnt_rst = pulse_w.ctrl.halfstrips_errcnt_rst;
    assign compout_errcnt_rst    = pulse_w.ctrl.compout_errcnt_rst;
    assign compin_inject         = pulse_w.ctrl.compin_inject;
    assign bx_delay              = pulse_w.ctrl.bx_delay;
    assign compout_expect        = pulse_w.ctrl.compout_expect;
    assign triad_persist         = pulse_w.ctrl.triad_persist;
    assign triad_persist1        = pulse_w.ctrl.triad_persist1;

    assign mux_a0_prev = mux1_w[MUX_A0_PREV_BIT];
    assign mux_a1_prev = mux1_w[MUX_A1_PREV_BIT];
    assign mux_a0_next = mux1_w[MUX_A0_NEXT_BIT];
    assign mux_a1_next = mux1_w[MUX_A1_NEXT_BIT];

    // Mux 2 holds the a0/a1 pairs interleaved, one pair per mux
    always_comb
    begin
        for (int i = 0; i < 16; i++)
        begin
            mux_a0[i] = mux2_w[2*i];
            mux_a1[i] = mux2_w[2*i + 1];
        end
    end

    assign halfstrips_expect = slice_word[REG_HS_EXPECT];
    assign active_strip_mask = slice_word[REG_STRIP_MASK];

    assign adc_cs_n = adc_w[ADC_CS_N_BIT];
    assign adc_mosi = adc_w[ADC_MOSI_BIT];
    assign adc_sclk = adc_w[ADC_SCLK_BIT];
    assign ddd_al_n = ddd_w[DDD_AL_N_BIT];   // Address latch, active low
    assign ddd_mosi = ddd_w[DDD_MOSI_BIT];
    assign ddd_sclk = ddd_w[DDD_SCLK_BIT];

endmodule

// File: hdl/readback_mux.sv
`timescale 1ns/1ps

module readback_mux
    import serial_cmd_pkg::*;
    import detector_ctrl_pkg::*;
(
    reg_bus_if.readback                   bus,
    input  logic [NUM_CTRL_REGS-1:0][31:0] slice_rd,
    input  logic [31:0]                   halfstrips,
    input  logic [31:0]                   halfstrips_errcnt,
    input  logic                          compout_last,
    input  logic                          pulser_ready,
    input  logic                          adc_miso,
    input  logic                          ddd_miso
);

    logic [31:0] slice_or;
    logic        ctrl_hit;
    pulse_ctrl_u pulse_rb;
    logic [31:0] rdata_w;

    // --------------------
    // Writable registers
    // --------------------
    always_comb
    begin
        slice_or = 32'h0;
        ctrl_hit = 1'b0;
        for (int i = 0; i < NUM_CTRL_REGS; i++)
        begin
            slice_or = slice_or | slice_rd[i];     // At most one slice non-zero
            ctrl_hit = ctrl_hit | (bus.adr == CTRL_ADDR[i]);
        end
    end

    // Status bits go into the unstored upper positions
    always_comb
    begin
        pulse_rb                 = slice_or;
        pulse_rb.rb.compout_last = compout_last;
        pulse_rb.rb.pulser_ready = pulser_ready;
    end

    // --------------------
    // Word select
    // --------------------
    always_comb
    begin
        rdata_w = slice_or;
        if (bus.adr == ADR_HALFSTRIPS)
            rdata_w = halfstrips;
        else if (bus.adr == ADR_HALFSTRIPS_ERRCNT)
            rdata_w = halfstrips_errcnt;
        else if (!ctrl_hit)
            rdata_w = UNMAPPED_WORD;
        else if (bus.adr == CTRL_ADDR[REG_PULSE_CTRL])
            rdata_w = pulse_rb;
        else if (bus.adr == CTRL_ADDR[REG_ADC])
            rdata_w[MISO_BIT] = adc_miso;   // MISO readback
        else if (bus.adr == CTRL_ADDR[REG_DDD])
            rdata_w[MISO_BIT] = ddd_miso;
    end

    assign bus.rdata = rdata_w;

endmodule

// File: hdl/reg_bus_if.sv
`timescale 1ns/1ps

interface reg_bus_if;

    logic        wr_stb;    // One cycle per write frame
    logic [3:0]  adr;       // Held from command byte to next command
    logic [31:0] wdata;
    logic [31:0] rdata;     // Combinational readback for adr

    modport engine (
        output wr_stb,
        output adr,
        output wdata,
        input  rdata
    );

    modport slice (
        input  wr_stb,
        input  adr,
        input  wdata
    );

    modport readback (
        input  adr,
        output rdata
    );

endinterface

// File: hdl/serial_cmd_pkg.sv
package serial_cmd_pkg;

    // --------------------
    // Host byte protocol
    // --------------------

    // Opcode sits in the low nibble of the command byte, address in the high nibble
    localparam logic [3:0] OP_READ  = 4'hA;
    localparam logic [3:0] OP_WRITE = 4'h5;

    localparam int WORD_BYTES = 4; // Data bytes per frame, LSB first

    // --------------------
    // Register address map
    // --------------------

    localparam int NUM_CTRL_REGS = 8;

    // Slot of each writable register in the arrays below
    localparam int REG_COMP_CFG    = 0;
    localparam int REG_PULSE_CTRL  = 1;
    localparam int REG_MUX1        = 2;
    localparam int REG_MUX2        = 3;
    localparam int REG_HS_EXPECT   = 4;
    localparam int REG_STRIP_MASK  = 5;
    localparam int REG_ADC         = 6;
    localparam int REG_DDD         = 7;

    localparam logic [3:0] CTRL_ADDR [NUM_CTRL_REGS] = '{
        4'h1,   // Comparator config
        4'h2,   // Pulse control
        4'h3,   // Mux 1
        4'h4,   // Mux 2
        4'h6,   // Halfstrip expect
        4'hC,   // Active strip mask
        4'h8,   // ADC bit-bang
        4'h9    // DDD bit-bang
    };

    // Read-only words
    localparam logic [3:0] ADR_HALFSTRIPS        = 4'h5;
    localparam logic [3:0] ADR_HALFSTRIPS_ERRCNT = 4'h7;

    localparam logic [31:0] UNMAPPED_WORD = 32'hDEAD_BEEF;

endpackage

// File: hdl/serial_frame_engine.sv
`timescale 1ns/1ps

module serial_frame_engine
    import serial_cmd_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,

    input  logic [7:0] rx_byte,
    input  logic       rx_valid,
    output logic       rx_ready,

    output logic [7:0] tx_byte,
    output logic       tx_valid,
    input  logic       tx_ready,

    reg_bus_if.engine  bus
);

    localparam int CNT_W = $clog2(WORD_BYTES);
    localparam logic [CNT_W-1:0] LAST_BYTE = CNT_W'(WORD_BYTES - 1);

    // --------------------
    // FSM encoding
    // --------------------
    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_RX_DATA = 3'd1;
    localparam logic [2:0] ST_COMMIT  = 3'd2;
    localparam logic [2:0] ST_RD_LOAD = 3'd3;
    localparam logic [2:0] ST_TX      = 3'd4;

    logic [2:0]       state;
    logic [CNT_W-1:0] byte_cnt;
    logic [3:0]       adr_q;
    logic [31:0]      word_q;   // Write assembly and read shift-out share this
    logic             rx_fire;
    logic             tx_fire;

    assign rx_ready = (state == ST_IDLE) || (state == ST_RX_DATA);
    assign rx_fire  = rx_valid && rx_ready;
    assign tx_fire  = tx_valid && tx_ready;

    assign tx_byte    = word_q[7:0];            // LSB goes out first
    assign bus.adr    = adr_q;
    assign bus.wdata  = word_q;
    assign bus.wr_stb = (state == ST_COMMIT);

    // --------------------
    // Control
    // --------------------
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= ST_IDLE;
            byte_cnt <= '0;
            adr_q    <= '0;
            tx_valid <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    byte_cnt <= '0;
                    if (rx_fire)
                    begin
                        adr_q <= rx_byte[7:4];
                        if (rx_byte[3:0] == OP_WRITE)
                            state <= ST_RX_DATA;
                        else if (rx_byte[3:0] == OP_READ)
                            state <= ST_RD_LOAD;
                        // Unknown opcodes are swallowed here
                    end
                end

                ST_RX_DATA:
                begin
                    if (rx_fire)
                    begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == LAST_BYTE)
                            state <= ST_COMMIT;
                    end
                end

                ST_COMMIT:
                    state <= ST_IDLE;       // wr_stb high for this cycle only

                ST_RD_LOAD:
                begin
                    byte_cnt <= '0;
                    tx_valid <= 1'b1;       // First byte valid with captured rdata
                    state    <= ST_TX;
                end

                ST_TX:
                begin
                    // Stalls indefinitely on tx_ready low
                    if (tx_fire)
                    begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == LAST_BYTE)
                        begin
                            tx_valid <= 1'b0;
                            state    <= ST_IDLE;
                        end
                    end
                end

                default:
                begin
                    tx_valid <= 1'b0;
                    state    <= ST_IDLE;
                end
            endcase
        end
    end

    // --------------------
    // Data path
    // --------------------
    always_ff @(posedge clk)
    begin
        if ((state == ST_RX_DATA) && rx_fire)
            word_q <= {rx_byte, word_q[31:8]};  // Shift in from the top
        else if (state == ST_RD_LOAD)
            word_q <= bus.rdata;
        else if (tx_fire)
            word_q <= {8'h00, word_q[31:8]};
    end

endmodule
